// File: include/vec_settings.svh
// Vector coprocessor settings
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Lane count, power of two
`define VEC_NR_LANES 4

// Element slots per register in each lane, power of two
`define VEC_ELEMS_PER_LANE 4

`define VEC_ELEM_WIDTH 32

// Register index is 3 bits wide
`define VEC_NR_VREGS 8

// Field positions in the 32-bit instruction word
`define VEC_OP_LSB 0
`define VEC_VD_LSB 8
`define VEC_VS1_LSB 12
`define VEC_VS2_LSB 16

`endif

// File: verilog/vec_pkg.sv
// Vector coprocessor types
`include "vec_settings.svh"

package vec_pkg;

  typedef logic [`VEC_ELEM_WIDTH-1:0] elem_t;

  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  // Opcodes 9 to 15 are illegal
  typedef enum logic [3:0] {
    VEC_VID     = 4'd0,
    VEC_VMV_VX  = 4'd1,
    VEC_VADD_VV = 4'd2,
    VEC_VSUB_VV = 4'd3,
    VEC_VAND_VV = 4'd4,
    VEC_VOR_VV  = 4'd5,
    VEC_VXOR_VV = 4'd6,
    VEC_VADD_VX = 4'd7,
    VEC_VEXT    = 4'd8
  } vec_op_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_BUSY,
    SEQ_RESP
  } seq_state_e;

  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_RUN,
    LANE_EXT
  } lane_state_e;

endpackage

// File: verilog/vec_dispatcher.sv
// Vector instruction dispatcher
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_dispatcher import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // Core request side
  input  logic        req_valid_i,
  input  logic [31:0] req_insn_i,
  input  elem_t       req_scalar_i,
  output logic        req_ready_o,
  // Sequencer side
  output logic        issue_valid_o,
  output vec_op_e     issue_op_o,
  output logic        issue_illegal_o,
  output vreg_idx_t   issue_vd_o,
  output vreg_idx_t   issue_vs1_o,
  output vreg_idx_t   issue_vs2_o,
  output elem_t       issue_scalar_o,
  input  logic        issue_ready_i
);

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  logic [$bits(vec_op_e)-1:0] dec_opcode;
  logic                       dec_illegal;
  vreg_idx_t                  dec_vd;
  vreg_idx_t                  dec_vs1;
  vreg_idx_t                  dec_vs2;
  logic                       req_fire;

  always_comb begin
    dec_opcode  = req_insn_i[`VEC_OP_LSB +: $bits(vec_op_e)];
    dec_vd      = req_insn_i[`VEC_VD_LSB +: $bits(vreg_idx_t)];
    dec_vs1     = req_insn_i[`VEC_VS1_LSB +: $bits(vreg_idx_t)];
    dec_vs2     = req_insn_i[`VEC_VS2_LSB +: $bits(vreg_idx_t)];
    // Anything past the scalar read has no meaning
    dec_illegal = (dec_opcode > VEC_VEXT);
  end

  ////////////////////////////////////////////////////////////
  // Holding register
  ////////////////////////////////////////////////////////////

  // Free now, or drained by the sequencer this cycle
  assign req_ready_o = !issue_valid_o || issue_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_valid_o <= 1'b0;
    end else if (req_fire) begin
      issue_valid_o <= 1'b1;
    end else if (issue_ready_i) begin
      issue_valid_o <= 1'b0;
    end
  end

  // Decoded payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      issue_op_o      <= vec_op_e'(dec_opcode);
      issue_illegal_o <= dec_illegal;
      issue_vd_o      <= dec_vd;
      issue_vs1_o     <= dec_vs1;
      issue_vs2_o     <= dec_vs2;
      issue_scalar_o  <= req_scalar_i;
    end
  end

endmodule

// File: verilog/vec_sequencer.sv
// Vector instruction sequencer
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Dispatcher side
  input  logic                        issue_valid_i,
  input  vec_op_e                     issue_op_i,
  input  logic                        issue_illegal_i,
  input  vreg_idx_t                   issue_vd_i,
  input  vreg_idx_t                   issue_vs1_i,
  input  vreg_idx_t                   issue_vs2_i,
  input  elem_t                       issue_scalar_i,
  output logic                        issue_ready_o,
  // Lane broadcast
  output logic                        lane_start_o,
  output vec_op_e                     lane_op_o,
  output vreg_idx_t                   lane_vd_o,
  output vreg_idx_t                   lane_vs1_o,
  output vreg_idx_t                   lane_vs2_o,
  output elem_t                       lane_scalar_o,
  input  logic [`VEC_NR_LANES-1:0]    lane_done_i,
  input  elem_t [`VEC_NR_LANES-1:0]   lane_ext_data_i,
  // Core response side
  output logic                        resp_valid_o,
  output elem_t                       resp_result_o,
  output logic                        resp_error_o,
  input  logic                        resp_ready_i
);

  localparam int unsigned LANE_W = $clog2(`VEC_NR_LANES);

  seq_state_e        state_q;
  logic [LANE_W-1:0] lane_sel_q;
  logic              issue_fire;

  // One instruction at a time
  assign issue_ready_o = (state_q == SEQ_IDLE);
  assign issue_fire    = issue_valid_i && issue_ready_o;
  assign resp_valid_o  = (state_q == SEQ_RESP);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= SEQ_IDLE;
      lane_start_o <= 1'b0;
    end else begin
      lane_start_o <= 1'b0;
      case (state_q)
        SEQ_IDLE: if (issue_fire) begin
          // Illegal ops never reach the lanes
          state_q      <= issue_illegal_i ? SEQ_RESP : SEQ_BUSY;
          lane_start_o <= !issue_illegal_i;
        end
        // All lanes finish together
        SEQ_BUSY: if (&lane_done_i) state_q <= SEQ_RESP;
        SEQ_RESP: if (resp_ready_i) state_q <= SEQ_IDLE;
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Broadcast payload and response data
  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      lane_op_o     <= issue_op_i;
      lane_vd_o     <= issue_vd_i;
      lane_vs1_o    <= issue_vs1_i;
      lane_vs2_o    <= issue_vs2_i;
      lane_scalar_o <= issue_scalar_i;
      // Low index bits pick the lane holding the element
      lane_sel_q    <= issue_scalar_i[LANE_W-1:0];
      resp_error_o  <= issue_illegal_i;
      resp_result_o <= '0;
    end else if (state_q == SEQ_BUSY && (&lane_done_i)) begin
      resp_result_o <= (lane_op_o == VEC_VEXT) ? lane_ext_data_i[lane_sel_q] : '0;
    end
  end

endmodule

// File: verilog/vec_lane.sv
// Vector lane
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      start_i,
  input  vec_op_e   op_i,
  input  vreg_idx_t vd_i,
  input  vreg_idx_t vs1_i,
  input  vreg_idx_t vs2_i,
  input  elem_t     scalar_i,
  output logic      done_o,
  output elem_t     ext_data_o
);

  localparam int unsigned LANE_W = $clog2(`VEC_NR_LANES);
  localparam int unsigned SLOT_W = $clog2(`VEC_ELEMS_PER_LANE);

  // Register file slice
  elem_t vrf [`VEC_NR_VREGS][`VEC_ELEMS_PER_LANE];

  lane_state_e       state_q;
  logic [SLOT_W-1:0] slot_q;
  logic              slot_last;
  vec_op_e           op_q;
  vreg_idx_t         vd_q;
  vreg_idx_t         vs1_q;
  vreg_idx_t         vs2_q;
  elem_t             scalar_q;
  logic [SLOT_W-1:0] ext_slot;
  elem_t             opnd_a;
  elem_t             opnd_b;
  elem_t             elem_idx;
  elem_t             alu_res;

  assign slot_last = (slot_q == SLOT_W'(`VEC_ELEMS_PER_LANE - 1));
  assign done_o    = (state_q == LANE_RUN && slot_last) || (state_q == LANE_EXT);

  // High index bits give the slot within this lane
  assign ext_slot = scalar_i[LANE_W +: SLOT_W];

  ////////////////////////////////////////////////////////////
  // Integer ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    opnd_a   = vrf[vs1_q][slot_q];
    opnd_b   = vrf[vs2_q][slot_q];
    // Global element number of this slot
    elem_idx = elem_t'(slot_q) * `VEC_NR_LANES + LANE_ID;
    case (op_q)
      VEC_VID:     alu_res = elem_idx;
      VEC_VMV_VX:  alu_res = scalar_q;
      VEC_VADD_VV: alu_res = opnd_b + opnd_a;
      VEC_VSUB_VV: alu_res = opnd_b - opnd_a;
      VEC_VAND_VV: alu_res = opnd_b & opnd_a;
      VEC_VOR_VV:  alu_res = opnd_b | opnd_a;
      VEC_VXOR_VV: alu_res = opnd_b ^ opnd_a;
      VEC_VADD_VX: alu_res = opnd_b + scalar_q;
      default:     alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control and register file
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LANE_IDLE;
      slot_q  <= '0;
      for (int v = 0; v < `VEC_NR_VREGS; v++) begin
        for (int s = 0; s < `VEC_ELEMS_PER_LANE; s++) begin
          vrf[v][s] <= '0;
        end
      end
    end else begin
      case (state_q)
        LANE_IDLE: if (start_i) begin
          slot_q  <= '0;
          state_q <= (op_i == VEC_VEXT) ? LANE_EXT : LANE_RUN;
        end
        LANE_RUN: begin
          // One slot per cycle
          vrf[vd_q][slot_q] <= alu_res;
          slot_q            <= slot_q + 1'b1;
          if (slot_last) state_q <= LANE_IDLE;
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  // Latched operation and scalar read data
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q     <= op_i;
      vd_q     <= vd_i;
      vs1_q    <= vs1_i;
      vs2_q    <= vs2_i;
      scalar_q <= scalar_i;
      if (op_i == VEC_VEXT) ext_data_o <= vrf[vs2_i][ext_slot];
    end
  end

endmodule

// File: verilog/vec_top.sv
// Vector coprocessor top
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_top import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // Core request
  input  logic        req_valid_i,
  input  logic [31:0] req_insn_i,
  input  elem_t       req_scalar_i,
  output logic        req_ready_o,
  // Core response
  output logic        resp_valid_o,
  output elem_t       resp_result_o,
  output logic        resp_error_o,
  input  logic        resp_ready_i
);

  // Dispatcher to sequencer
  logic      issue_valid;
  vec_op_e   issue_op;
  logic      issue_illegal;
  vreg_idx_t issue_vd;
  vreg_idx_t issue_vs1;
  vreg_idx_t issue_vs2;
  elem_t     issue_scalar;
  logic      issue_ready;

  // Sequencer to lanes
  logic                      lane_start;
  vec_op_e                   lane_op;
  vreg_idx_t                 lane_vd;
  vreg_idx_t                 lane_vs1;
  vreg_idx_t                 lane_vs2;
  elem_t                     lane_scalar;
  logic [`VEC_NR_LANES-1:0]  lane_done;
  elem_t [`VEC_NR_LANES-1:0] lane_ext_data;

  vec_dispatcher dispatcher_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_insn_i      (req_insn_i),
    .req_scalar_i    (req_scalar_i),
    .req_ready_o     (req_ready_o),
    .issue_valid_o   (issue_valid),
    .issue_op_o      (issue_op),
    .issue_illegal_o (issue_illegal),
    .issue_vd_o      (issue_vd),
    .issue_vs1_o     (issue_vs1),
    .issue_vs2_o     (issue_vs2),
    .issue_scalar_o  (issue_scalar),
    .issue_ready_i   (issue_ready)
  );

  vec_sequencer sequencer_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .issue_valid_i   (issue_valid),
    .issue_op_i      (issue_op),
    .issue_illegal_i (issue_illegal),
    .issue_vd_i      (issue_vd),
    .issue_vs1_i     (issue_vs1),
    .issue_vs2_i     (issue_vs2),
    .issue_scalar_i  (issue_scalar),
    .issue_ready_o   (issue_ready),
    .lane_start_o    (lane_start),
    .lane_op_o       (lane_op),
    .lane_vd_o       (lane_vd),
    .lane_vs1_o      (lane_vs1),
    .lane_vs2_o      (lane_vs2),
    .lane_scalar_o   (lane_scalar),
    .lane_done_i     (lane_done),
    .lane_ext_data_i (lane_ext_data),
    .resp_valid_o    (resp_valid_o),
    .resp_result_o   (resp_result_o),
    .resp_error_o    (resp_error_o),
    .resp_ready_i    (resp_ready_i)
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) lane_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .start_i    (lane_start),
      .op_i       (lane_op),
      .vd_i       (lane_vd),
      .vs1_i      (lane_vs1),
      .vs2_i      (lane_vs2),
      .scalar_i   (lane_scalar),
      .done_o     (lane_done[l]),
      .ext_data_o (lane_ext_data[l])
    );
  end

endmodule

// File: verification/tb_vec_model.svh
// Vector coprocessor reference model
`ifndef TB_VEC_MODEL_SVH
`define TB_VEC_MODEL_SVH

  localparam int TOTAL_ELEMS = `VEC_NR_LANES * `VEC_ELEMS_PER_LANE;

  // Full register file, indexed by global element number
  elem_t model_vrf [`VEC_NR_VREGS][TOTAL_ELEMS];

  // Expected responses in acceptance order
  elem_t exp_result_q [$];
  logic  exp_error_q [$];

  task automatic model_reset();
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      for (int i = 0; i < TOTAL_ELEMS; i++) begin
        model_vrf[v][i] = elem_t'(0);
      end
    end
    exp_result_q.delete();
    exp_error_q.delete();
  endtask

  task automatic model_accept(input logic [31:0] insn, input elem_t scalar);
    logic [3:0] op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elem_t      a;
    elem_t      b;
    elem_t      res;
    op  = insn[`VEC_OP_LSB +: 4];
    vd  = insn[`VEC_VD_LSB +: $bits(vreg_idx_t)];
    vs1 = insn[`VEC_VS1_LSB +: $bits(vreg_idx_t)];
    vs2 = insn[`VEC_VS2_LSB +: $bits(vreg_idx_t)];
    if (op > 4'd8) begin
      // Rejected, no register changes
      exp_result_q.push_back(elem_t'(0));
      exp_error_q.push_back(1'b1);
    end else if (op == VEC_VEXT) begin
      exp_result_q.push_back(model_vrf[vs2][scalar % TOTAL_ELEMS]);
      exp_error_q.push_back(1'b0);
    end else begin
      for (int i = 0; i < TOTAL_ELEMS; i++) begin
        a = model_vrf[vs1][i];
        b = model_vrf[vs2][i];
        case (op)
          VEC_VID:     res = elem_t'(i);
          VEC_VMV_VX:  res = scalar;
          VEC_VADD_VV: res = a + b;
          VEC_VSUB_VV: res = b - a;
          VEC_VAND_VV: res = a & b;
          VEC_VOR_VV:  res = a | b;
          VEC_VXOR_VV: res = a ^ b;
          default:     res = b + scalar;
        endcase
        model_vrf[vd][i] = res;
      end
      exp_result_q.push_back(elem_t'(0));
      exp_error_q.push_back(1'b0);
    end
  endtask

`endif

// File: verification/tb_vec.sv
// Vector coprocessor testbench
`timescale 1ns/1ns
`include "vec_settings.svh"

module tb_vec import vec_pkg::*; ();

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 10;
  localparam int N_ZERO_READS   = 8;
  localparam int N_VID_READS    = 24;
  localparam int N_RANDOM       = 300;
  localparam int MAX_GAP        = 3;
  localparam int MAX_STALL      = 8;
  // Random phase adds a read after each illegal op
  localparam int NUM_INSN       = N_ZERO_READS + 1 + N_VID_READS + 2 * N_RANDOM;
  localparam int DRAIN_LIMIT    = 200;
  localparam int TIMEOUT_CYCLES = NUM_INSN * (`VEC_ELEMS_PER_LANE + 10 + MAX_GAP + MAX_STALL)
                                  + RESET_CYCLES + DRAIN_LIMIT;

  logic        clk_i;
  logic        rst_i;
  logic        req_valid_i;
  logic [31:0] req_insn_i;
  elem_t       req_scalar_i;
  logic        req_ready_o;
  logic        resp_valid_o;
  elem_t       resp_result_o;
  logic        resp_error_o;
  logic        resp_ready_i;

  integer seed       = 32'h97a2_1081;
  integer stall_seed = 32'h97a2_1081 ^ 32'h0000_ffff;
  int     sent_count;
  int     resp_count;
  int     stall_left;

  `include "tb_vec_model.svh"

  vec_top dut_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_insn_i    (req_insn_i),
    .req_scalar_i  (req_scalar_i),
    .req_ready_o   (req_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_result_o (resp_result_o),
    .resp_error_o  (resp_error_o),
    .resp_ready_i  (resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int rand_range(inout integer s, input int n);
    return {$random(s)} % n;
  endfunction

  function automatic vreg_idx_t rand_reg();
    return vreg_idx_t'(rand_range(seed, `VEC_NR_VREGS));
  endfunction

  // Random word with the fields laid over it
  function automatic logic [31:0] make_insn(input logic [3:0] op, input vreg_idx_t vd,
                                            input vreg_idx_t vs1, input vreg_idx_t vs2);
    logic [31:0] insn;
    insn = $random(seed);
    insn[`VEC_OP_LSB +: 4]                   = op;
    insn[`VEC_VD_LSB +: $bits(vreg_idx_t)]  = vd;
    insn[`VEC_VS1_LSB +: $bits(vreg_idx_t)] = vs1;
    insn[`VEC_VS2_LSB +: $bits(vreg_idx_t)] = vs2;
    return insn;
  endfunction

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_result(input string name, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_error(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_insn(input logic [31:0] insn, input elem_t scalar);
    int gap;
    gap = rand_range(seed, MAX_GAP + 1);
    req_valid_i = 1'b0;
    repeat (gap) @(negedge clk_i);
    req_valid_i  = 1'b1;
    req_insn_i   = insn;
    req_scalar_i = scalar;
    while (!req_ready_o) @(negedge clk_i);
    model_accept(insn, scalar);
    sent_count++;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Response side with random back-pressure
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (stall_left > 0) begin
        resp_ready_i = 1'b0;
        stall_left--;
      end else if (rand_range(stall_seed, 6) == 0) begin
        resp_ready_i = 1'b0;
        stall_left   = rand_range(stall_seed, MAX_STALL);
      end else begin
        resp_ready_i = 1'b1;
      end
      if (resp_valid_o && resp_ready_i) begin
        if (exp_result_q.size() == 0) begin
          $display("A response arrived while no request was outstanding");
          abort_run();
        end else begin
          check_result("resp_result_o", resp_result_o, exp_result_q.pop_front());
          check_error("resp_error_o", resp_error_o, exp_error_q.pop_front());
          resp_count++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int         idx;
    logic [3:0] op;
    vreg_idx_t  vd;
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_insn_i   = '0;
    req_scalar_i = '0;
    resp_ready_i = 1'b0;
    stall_left   = 0;
    sent_count   = 0;
    resp_count   = 0;
    model_reset();
    repeat (RESET_CYCLES) @(negedge clk_i);

    // Handshake state out of reset
    check_flag("req_ready_o", req_ready_o, 1'b1);
    check_flag("resp_valid_o", resp_valid_o, 1'b0);
    rst_i = 1'b0;

    // Registers read as zero out of reset
    repeat (N_ZERO_READS) send_insn(make_insn(VEC_VEXT, rand_reg(), rand_reg(), rand_reg()),
                                    $random(seed));

    // Index fill shows the element to lane mapping
    vd = rand_reg();
    send_insn(make_insn(VEC_VID, vd, rand_reg(), rand_reg()), $random(seed));
    repeat (N_VID_READS) send_insn(make_insn(VEC_VEXT, rand_reg(), rand_reg(), vd), $random(seed));

    // Mixed operations, reads and illegal opcodes
    repeat (N_RANDOM) begin
      case (rand_range(seed, 8))
        0, 1:    op = VEC_VEXT;
        2:       op = 4'(9 + rand_range(seed, 7));
        default: op = 4'(rand_range(seed, 8));
      endcase
      vd = rand_reg();
      send_insn(make_insn(op, vd, rand_reg(), rand_reg()), $random(seed));
      if (op > 4'd8) begin
        send_insn(make_insn(VEC_VEXT, rand_reg(), rand_reg(), vd), $random(seed));
      end
    end

    // Let the last responses drain
    idx = 0;
    while (resp_count < sent_count && idx < DRAIN_LIMIT) begin
      @(negedge clk_i);
      idx++;
    end
    if (resp_count != sent_count) begin
      $display("%0d responses were still missing at the end", sent_count - resp_count);
      abort_run();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles without the run completing", TIMEOUT_CYCLES);
    abort_run();
  end

endmodule

// File: tb.f
+incdir+include
+incdir+verification
verilog/vec_pkg.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_top.sv
verification/tb_vec.sv

// File: Bender.yml
package:
  name: vec_coproc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/vec_pkg.sv
      - verilog/vec_dispatcher.sv
      - verilog/vec_sequencer.sv
      - verilog/vec_lane.sv
      - verilog/vec_top.sv
  - target: test
    include_dirs:
      - include
      - verification
    files:
      - verification/tb_vec.sv
